// File: Makefile
# Verilator build and run for the camera to AXI capture testbench
# usage: make compile | make run | make clean

VERILATOR ?= verilator
TOP       ?= tb_cam_axi
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0 -Wno-fatal
SOURCES   := $(wildcard hw/*.sv hw/*.svh bench/*.sv)

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides, the binary exits nonzero on $fatal
run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/tb_cam_axi.sv
`timescale 1ns/1ns
`include "cam_store_defines.svh"

module tb_cam_axi
    import cam_store_pkg::*;
();

    localparam int beats  = `CAM_BURST_BEATS;
    localparam int n_rows = 4;

    typedef struct {
        int          frames;
        int          lines;
        int          line_bytes;
        logic [31:0] base;
        logic [31:0] size;
        int          stall_pct;
        bit          slverr;
    } row_t;

    row_t rows [n_rows];

    logic        clk;
    logic        ov_rstn_sync;
    logic        ccd_pclk;
    logic        ccd_vsync;
    logic        ccd_href;
    logic [7:0]  ccd_data;
    logic [31:0] store_base_addr;
    logic [31:0] store_num;
    logic [31:0] m_awaddr;
    logic        m_awvalid;
    logic        m_awready;
    logic [31:0] m_wdata;
    logic        m_wlast;
    logic        m_wvalid;
    logic        m_wready;
    axi_resp_e   m_bresp;
    logic        m_bvalid;
    logic        m_bready;
    logic        wr_error;

    logic [31:0] exp_words [$];     // words still to appear on the W channel
    int          stall_pct;
    bit          slverr_row;
    logic [31:0] exp_addr;
    int          beat_idx;
    int          bursts_done;
    bit          resp_pending;
    bit          b_fired;
    bit          b_was_err;
    bit          err_expected;
    bit          aw_wait;
    logic [31:0] aw_held;
    bit          w_wait;
    logic [31:0] w_held;
    int          cycle_cnt;
    int          cycle_limit;

    cam_axi_top u_dut (
        .clk             (clk),
        .ov_rstn_sync    (ov_rstn_sync),
        .ccd_pclk        (ccd_pclk),
        .ccd_vsync       (ccd_vsync),
        .ccd_href        (ccd_href),
        .ccd_data        (ccd_data),
        .store_base_addr (store_base_addr),
        .store_num       (store_num),
        .m_awaddr        (m_awaddr),
        .m_awvalid       (m_awvalid),
        .m_awready       (m_awready),
        .m_wdata         (m_wdata),
        .m_wlast         (m_wlast),
        .m_wvalid        (m_wvalid),
        .m_wready        (m_wready),
        .m_bresp         (m_bresp),
        .m_bvalid        (m_bvalid),
        .m_bready        (m_bready),
        .wr_error        (wr_error)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        ccd_pclk = 1'b0;
        forever #28 ccd_pclk = ~ccd_pclk;
    end

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
            abort_run();
        end
    endtask

    task automatic stop_with(input string why);
        $display("%s at %0t", why, $time);
        abort_run();
    endtask

    function automatic bit roll_ready();
        return ($urandom % 100) >= stall_pct;
    endfunction

    task automatic cam_cycle(input logic vs, input logic hr, input logic [7:0] d);
        @(negedge ccd_pclk);
        ccd_vsync = vs;
        ccd_href  = hr;
        ccd_data  = d;
    endtask

    // one frame: blanking with junk bytes, then lines of random pixels
    task automatic send_frame(input int lines, input int line_bytes);
        logic [31:0] word;
        logic [7:0]  px;
        int          nb;
        word = '0;
        nb   = 0;
        repeat (4) cam_cycle(1'b1, 1'b1, 8'($urandom));   // vsync high, must be ignored
        repeat (2) cam_cycle(1'b0, 1'b0, 8'h00);
        for (int l = 0; l < lines; l++) begin
            for (int b = 0; b < line_bytes; b++) begin
                px = 8'($urandom);
                cam_cycle(1'b0, 1'b1, px);
                word[8*nb +: 8] = px;   // first byte of a word in 7:0
                nb++;
                if (nb == 4) begin
                    exp_words.push_back(word);
                    nb = 0;
                end
            end
            repeat (3) cam_cycle(1'b0, 1'b0, 8'h00);
        end
        // leftover bytes die with the next vsync
    endtask

    task automatic run_camera(input int frames, input int lines, input int line_bytes);
        repeat (6) cam_cycle(1'b0, 1'b1, 8'($urandom));   // no frame started yet
        for (int f = 0; f < frames; f++) begin
            send_frame(lines, line_bytes);
        end
        repeat (3) cam_cycle(1'b1, 1'b0, 8'h00);
        cam_cycle(1'b0, 1'b0, 8'h00);
    endtask

    // memory side, evaluated mid cycle for the next rising edge
    task automatic respond_cycle();
        bit          aw_fire;
        bit          w_fire;
        bit          b_fire;
        logic [31:0] next_addr;
        if (b_fired) begin
            m_bvalid    = 1'b0;
            b_fired     = 1'b0;
            bursts_done++;
            if (b_was_err) begin
                err_expected = 1'b1;
            end
        end
        check_value("wr_error", 32'(wr_error), 32'(err_expected));
        check_value("m_bready", 32'(m_bready), 32'(resp_pending));
        if (aw_wait) begin
            check_value("m_awvalid", 32'(m_awvalid), 32'd1);
            check_value("m_awaddr", m_awaddr, aw_held);
        end
        if (w_wait) begin
            check_value("m_wvalid", 32'(m_wvalid), 32'd1);
            check_value("m_wdata", m_wdata, w_held);
        end
        if (resp_pending && !m_bvalid && roll_ready()) begin
            m_bvalid = 1'b1;
            if (slverr_row && bursts_done == 0) begin
                m_bresp = SLVERR;
            end else begin
                m_bresp = OKAY;
            end
        end
        m_awready = roll_ready();
        m_wready  = roll_ready();

        aw_fire = m_awvalid && m_awready;
        w_fire  = m_wvalid && m_wready;
        b_fire  = m_bvalid && m_bready;
        aw_wait = m_awvalid && !m_awready;
        aw_held = m_awaddr;
        w_wait  = m_wvalid && !m_wready;
        w_held  = m_wdata;

        if (aw_fire) begin
            if (exp_words.size() < beats) begin
                stop_with("burst started before a full burst of words was captured");
            end else begin
                check_value("m_awaddr", m_awaddr, exp_addr);
            end
            next_addr = exp_addr + `CAM_BURST_BYTES;
            if (next_addr >= store_base_addr + store_num) begin
                next_addr = store_base_addr;   // ring wrap
            end
            exp_addr = next_addr;
            beat_idx = 0;
        end
        if (w_fire) begin
            if (exp_words.size() == 0) begin
                stop_with("data beat with no captured word left");
            end else begin
                check_value("m_wdata", m_wdata, exp_words.pop_front());
            end
            check_value("m_wlast", 32'(m_wlast), 32'(beat_idx == beats - 1));
            beat_idx++;
            if (beat_idx == beats) begin
                resp_pending = 1'b1;
                beat_idx     = 0;
            end
        end
        if (b_fire) begin
            b_fired      = 1'b1;
            b_was_err    = (m_bresp != OKAY);
            resp_pending = 1'b0;
        end
    endtask

    always @(negedge clk) begin
        if (!ov_rstn_sync) begin
            m_awready    = 1'b0;
            m_wready     = 1'b0;
            m_bvalid     = 1'b0;
            m_bresp      = OKAY;
            exp_addr     = store_base_addr;
            beat_idx     = 0;
            bursts_done  = 0;
            resp_pending = 1'b0;
            b_fired      = 1'b0;
            err_expected = 1'b0;
            aw_wait      = 1'b0;
            w_wait       = 1'b0;
        end else begin
            respond_cycle();
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            stop_with("timeout, the writer did not finish the expected bursts in time");
        end
    end

    task automatic run_row(input row_t row, input int idx);
        int exp_total;
        int exp_bursts;
        @(negedge clk);
        ov_rstn_sync    = 1'b0;
        store_base_addr = row.base;
        store_num       = row.size;
        stall_pct       = row.stall_pct;
        slverr_row      = row.slverr;
        exp_words.delete();
        repeat (16) @(negedge clk);
        ov_rstn_sync = 1'b1;

        exp_total  = row.frames * ((row.lines * row.line_bytes) / 4);
        exp_bursts = exp_total / beats;
        $display("row %0d: %0d words, %0d bursts expected", idx, exp_total, exp_bursts);
        run_camera(row.frames, row.lines, row.line_bytes);
        while (bursts_done < exp_bursts) begin
            @(negedge clk);
        end
        repeat (200) @(negedge clk);   // leftover words must stay put
        check_value("bursts", 32'(bursts_done), 32'(exp_bursts));
        check_value("leftover words", 32'(exp_words.size()), 32'(exp_total - exp_bursts * beats));
        check_value("m_awvalid", 32'(m_awvalid), 32'd0);
    endtask

    initial begin
        int total_bytes;
        ov_rstn_sync    = 1'b0;
        ccd_vsync       = 1'b0;
        ccd_href        = 1'b0;
        ccd_data        = 8'h00;
        store_base_addr = '0;
        store_num       = '0;
        m_awready       = 1'b0;
        m_wready        = 1'b0;
        m_bvalid        = 1'b0;
        m_bresp         = OKAY;
        stall_pct       = 0;
        slverr_row      = 1'b0;
        cycle_cnt       = 0;
        void'($urandom(27473));

        // frames, lines, bytes per line, base, size, stall %, slverr
        rows[0] = '{2, 4, 42, 32'h1000_0000, 32'h0000_0100, 0, 1'b0};
        rows[1] = '{3, 3, 30, 32'h2000_0040, 32'h0000_00c0, 50, 1'b1};
        rows[2] = '{1, 8, 64, 32'h8000_0000, 32'h0000_0080, 30, 1'b0};
        rows[3] = '{2, 5, 37, 32'h0000_f000, 32'h0000_1000, 70, 1'b1};

        total_bytes = 0;
        for (int r = 0; r < n_rows; r++) begin
            total_bytes += rows[r].frames * rows[r].lines * rows[r].line_bytes;
        end
        cycle_limit = (total_bytes * 56 * 4) / 40 + 2000;   // pclk 56 ns over clk 40 ns

        for (int r = 0; r < n_rows; r++) begin
            run_row(rows[r], r);
        end
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: files.f
+incdir+hw
hw/cam_store_pkg.sv
hw/dvp_capture.sv
hw/pixel_async_fifo.sv
hw/axi_burst_writer.sv
hw/cam_axi_top.sv
bench/tb_cam_axi.sv

// File: hw/axi_burst_writer.sv
`timescale 1ns/1ns
`include "cam_store_defines.svh"

module axi_burst_writer
    import cam_store_pkg::*;
(
    input  logic                   clk,
    input  logic                   ov_rstn_sync,
    input  logic                   burst_avail,
    input  logic [`CAM_DATA_W-1:0] fifo_rd_data,
    output logic                   fifo_rd_en,
    input  logic [`CAM_ADDR_W-1:0] store_base_addr,
    input  logic [`CAM_ADDR_W-1:0] store_num,
    output logic [`CAM_ADDR_W-1:0] m_awaddr,
    output logic                   m_awvalid,
    input  logic                   m_awready,
    output logic [`CAM_DATA_W-1:0] m_wdata,
    output logic                   m_wlast,
    output logic                   m_wvalid,
    input  logic                   m_wready,
    input  axi_resp_e              m_bresp,
    input  logic                   m_bvalid,
    output logic                   m_bready,
    output logic                   wr_error
);

    localparam int beat_w = $clog2(`CAM_BURST_BEATS);
    localparam logic [beat_w-1:0] last_beat = beat_w'(`CAM_BURST_BEATS - 1);
    localparam logic [`CAM_ADDR_W-1:0] burst_bytes = `CAM_ADDR_W'(`CAM_BURST_BYTES);

    writer_state_e           state;
    writer_state_e           next_state;
    logic [beat_w-1:0]       beat_cnt;
    logic [`CAM_ADDR_W-1:0]  addr_off;     // offset of the next burst in the ring
    logic [`CAM_ADDR_W-1:0]  next_off;
    logic                    aw_fire;
    logic                    w_fire;
    logic                    b_fire;

    assign m_awvalid = (state == ADDR);
    assign m_wvalid  = (state == DATA);
    assign m_bready  = (state == RESP);
    assign m_wlast   = (state == DATA) && (beat_cnt == last_beat);
    assign m_wdata   = fifo_rd_data;

    assign aw_fire    = m_awvalid && m_awready;
    assign w_fire     = m_wvalid && m_wready;
    assign b_fire     = m_bvalid && m_bready;
    assign fifo_rd_en = w_fire;

    always_comb begin
        next_state = state;
        case (state)
            IDLE: if (burst_avail) next_state = ADDR;
            ADDR: if (aw_fire) next_state = DATA;
            DATA: if (w_fire && m_wlast) next_state = RESP;
            RESP: if (b_fire) next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            beat_cnt <= '0;
        end else if (aw_fire) begin
            beat_cnt <= '0;
        end else if (w_fire) begin
            beat_cnt <= beat_cnt + 1'b1;
        end
    end

    // ring addressing, wraps back to the base
    assign next_off = addr_off + burst_bytes;

    always_ff @(posedge clk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            addr_off <= '0;
            wr_error <= 1'b0;
        end else if (b_fire) begin
            addr_off <= (next_off >= store_num) ? '0 : next_off;
            if (m_bresp != OKAY) begin
                wr_error <= 1'b1;   // sticky
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && burst_avail) begin
            m_awaddr <= store_base_addr + addr_off;
        end
    end

    aw_hold: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        m_awvalid && !m_awready |=> m_awvalid && $stable(m_awaddr))
        else $error("write address dropped or changed before handshake");

    w_hold: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        m_wvalid && !m_wready |=> m_wvalid && $stable(m_wdata) && $stable(m_wlast))
        else $error("write data dropped or changed before handshake");

    aw_with_burst: assert property (@(posedge clk) disable iff (!ov_rstn_sync)
        m_awvalid |-> burst_avail)
        else $error("write address issued without a full burst buffered");

endmodule

// File: hw/cam_axi_top.sv
`timescale 1ns/1ns
`include "cam_store_defines.svh"

module cam_axi_top
    import cam_store_pkg::*;
(
    input  logic                   clk,
    input  logic                   ov_rstn_sync,
    input  logic                   ccd_pclk,
    input  logic                   ccd_vsync,
    input  logic                   ccd_href,
    input  logic [7:0]             ccd_data,
    input  logic [`CAM_ADDR_W-1:0] store_base_addr,
    input  logic [`CAM_ADDR_W-1:0] store_num,
    output logic [`CAM_ADDR_W-1:0] m_awaddr,
    output logic                   m_awvalid,
    input  logic                   m_awready,
    output logic [`CAM_DATA_W-1:0] m_wdata,
    output logic                   m_wlast,
    output logic                   m_wvalid,
    input  logic                   m_wready,
    input  axi_resp_e              m_bresp,
    input  logic                   m_bvalid,
    output logic                   m_bready,
    output logic                   wr_error
);

    logic                   pix_rstn;
    logic                   fifo_wr_en;
    logic [`CAM_DATA_W-1:0] fifo_wr_data;
    logic                   fifo_full;
    logic                   fifo_rd_en;
    logic [`CAM_DATA_W-1:0] fifo_rd_data;
    logic                   burst_avail;

    // pixel clock domain
    dvp_capture u_capture (
        .ccd_pclk     (ccd_pclk),
        .ov_rstn_sync (ov_rstn_sync),
        .ccd_vsync    (ccd_vsync),
        .ccd_href     (ccd_href),
        .ccd_data     (ccd_data),
        .fifo_full    (fifo_full),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data),
        .pix_rstn     (pix_rstn)
    );

    pixel_async_fifo u_fifo (
        .wr_clk      (ccd_pclk),
        .wr_rstn     (pix_rstn),
        .wr_en       (fifo_wr_en),
        .wr_data     (fifo_wr_data),
        .full        (fifo_full),
        .rd_clk      (clk),
        .rd_rstn     (ov_rstn_sync),
        .rd_en       (fifo_rd_en),
        .rd_data     (fifo_rd_data),
        .burst_avail (burst_avail)
    );

    // system clock domain
    axi_burst_writer u_writer (
        .clk             (clk),
        .ov_rstn_sync    (ov_rstn_sync),
        .burst_avail     (burst_avail),
        .fifo_rd_data    (fifo_rd_data),
        .fifo_rd_en      (fifo_rd_en),
        .store_base_addr (store_base_addr),
        .store_num       (store_num),
        .m_awaddr        (m_awaddr),
        .m_awvalid       (m_awvalid),
        .m_awready       (m_awready),
        .m_wdata         (m_wdata),
        .m_wlast         (m_wlast),
        .m_wvalid        (m_wvalid),
        .m_wready        (m_wready),
        .m_bresp         (m_bresp),
        .m_bvalid        (m_bvalid),
        .m_bready        (m_bready),
        .wr_error        (wr_error)
    );

endmodule

// File: hw/cam_store_defines.svh
`ifndef CAM_STORE_DEFINES_SVH
`define CAM_STORE_DEFINES_SVH

// beats per write burst
// power of two, at most half the FIFO depth
`define CAM_BURST_BEATS 16

// FIFO address width, 2**6 = 64 words
`define CAM_FIFO_AW 6

// bus address width
`define CAM_ADDR_W 32

// word width, four packed pixel bytes
`define CAM_DATA_W 32

// address step per burst in bytes
`define CAM_BURST_BYTES (4 * `CAM_BURST_BEATS)

`endif

// File: hw/cam_store_pkg.sv
package cam_store_pkg;

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        ADDR = 2'd1,
        DATA = 2'd2,
        RESP = 2'd3
    } writer_state_e;

    typedef enum logic {
        WAIT_FRAME = 1'b0,
        IN_FRAME   = 1'b1
    } capture_state_e;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } axi_resp_e;

endpackage

// File: hw/dvp_capture.sv
`timescale 1ns/1ns
`include "cam_store_defines.svh"

module dvp_capture
    import cam_store_pkg::*;
(
    input  logic                   ccd_pclk,
    input  logic                   ov_rstn_sync,
    input  logic                   ccd_vsync,
    input  logic                   ccd_href,
    input  logic [7:0]             ccd_data,
    input  logic                   fifo_full,
    output logic                   fifo_wr_en,
    output logic [`CAM_DATA_W-1:0] fifo_wr_data,
    output logic                   pix_rstn
);

    logic [1:0]     rst_sync;
    capture_state_e state;
    logic           vsync_d;
    logic [1:0]     byte_cnt;
    logic [23:0]    pack_buf;   // first three bytes of the word
    logic           byte_ok;

    // release in the pixel domain, assert asynchronously
    always_ff @(posedge ccd_pclk or negedge ov_rstn_sync) begin
        if (!ov_rstn_sync) begin
            rst_sync <= 2'b00;
        end else begin
            rst_sync <= {rst_sync[0], 1'b1};
        end
    end

    assign pix_rstn = rst_sync[1];

    // frame tracking, a frame opens on the falling edge of vsync
    always_ff @(posedge ccd_pclk or negedge pix_rstn) begin
        if (!pix_rstn) begin
            state   <= WAIT_FRAME;
            vsync_d <= 1'b0;
        end else begin
            vsync_d <= ccd_vsync;
            case (state)
                WAIT_FRAME: begin
                    if (vsync_d && !ccd_vsync) begin
                        state <= IN_FRAME;
                    end
                end
                IN_FRAME: begin
                    if (ccd_vsync) begin
                        state <= WAIT_FRAME;
                    end
                end
                default: state <= WAIT_FRAME;
            endcase
        end
    end

    assign byte_ok = (state == IN_FRAME) && ccd_href && !ccd_vsync;

    always_ff @(posedge ccd_pclk or negedge pix_rstn) begin
        if (!pix_rstn) begin
            byte_cnt   <= 2'd0;
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= 1'b0;
            if (ccd_vsync) begin
                byte_cnt <= 2'd0;   // partial word at frame end is dropped
            end else if (byte_ok) begin
                byte_cnt   <= byte_cnt + 2'd1;
                fifo_wr_en <= (byte_cnt == 2'd3) && !fifo_full;   // lost when full
            end
        end
    end

    // little-endian packing, first byte lands in 7:0
    always_ff @(posedge ccd_pclk) begin
        if (byte_ok) begin
            case (byte_cnt)
                2'd0:    pack_buf[7:0]   <= ccd_data;
                2'd1:    pack_buf[15:8]  <= ccd_data;
                2'd2:    pack_buf[23:16] <= ccd_data;
                default: fifo_wr_data    <= {ccd_data, pack_buf};
            endcase
        end
    end

endmodule

// File: hw/pixel_async_fifo.sv
`timescale 1ns/1ns
`include "cam_store_defines.svh"

module pixel_async_fifo
    import cam_store_pkg::*;
(
    input  logic                   wr_clk,
    input  logic                   wr_rstn,
    input  logic                   wr_en,
    input  logic [`CAM_DATA_W-1:0] wr_data,
    output logic                   full,
    input  logic                   rd_clk,
    input  logic                   rd_rstn,
    input  logic                   rd_en,
    output logic [`CAM_DATA_W-1:0] rd_data,
    output logic                   burst_avail
);

    localparam int aw    = `CAM_FIFO_AW;
    localparam int depth = 1 << aw;
    localparam logic [aw:0] burst_beats = (aw + 1)'(`CAM_BURST_BEATS);

    logic [`CAM_DATA_W-1:0] mem [depth];

    logic [aw:0] wr_bin;
    logic [aw:0] wr_gray;
    logic [aw:0] wr_bin_next;
    logic [aw:0] rd_gray_w1;
    logic [aw:0] rd_gray_w2;    // read pointer seen by the write side

    logic [aw:0] rd_bin;
    logic [aw:0] rd_gray;
    logic [aw:0] rd_bin_next;
    logic [aw:0] wr_gray_r1;
    logic [aw:0] wr_gray_r2;    // write pointer seen by the read side
    logic [aw:0] wr_bin_rd;
    logic [aw:0] rd_fill;

    logic        empty;
    logic        wr_fire;
    logic        rd_fire;

    function automatic logic [aw:0] gray2bin(input logic [aw:0] g);
        logic [aw:0] b;
        b[aw] = g[aw];
        for (int i = aw - 1; i >= 0; i--) begin
            b[i] = b[i+1] ^ g[i];
        end
        return b;
    endfunction

    // write side
    assign full        = (wr_gray == {~rd_gray_w2[aw:aw-1], rd_gray_w2[aw-2:0]});
    assign wr_fire     = wr_en && !full;
    assign wr_bin_next = wr_bin + 1'b1;

    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_fire) begin
            wr_bin  <= wr_bin_next;
            wr_gray <= (wr_bin_next >> 1) ^ wr_bin_next;
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_fire) begin
            mem[wr_bin[aw-1:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge wr_rstn) begin
        if (!wr_rstn) begin
            rd_gray_w1 <= '0;
            rd_gray_w2 <= '0;
        end else begin
            rd_gray_w1 <= rd_gray;
            rd_gray_w2 <= rd_gray_w1;
        end
    end

    // read side, first word falls through
    assign empty       = (rd_gray == wr_gray_r2);
    assign rd_fire     = rd_en && !empty;
    assign rd_bin_next = rd_bin + 1'b1;
    assign rd_data     = mem[rd_bin[aw-1:0]];

    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_fire) begin
            rd_bin  <= rd_bin_next;
            rd_gray <= (rd_bin_next >> 1) ^ rd_bin_next;
        end
    end

    always_ff @(posedge rd_clk or negedge rd_rstn) begin
        if (!rd_rstn) begin
            wr_gray_r1 <= '0;
            wr_gray_r2 <= '0;
        end else begin
            wr_gray_r1 <= wr_gray;
            wr_gray_r2 <= wr_gray_r1;
        end
    end

    assign wr_bin_rd   = gray2bin(wr_gray_r2);
    assign rd_fill     = wr_bin_rd - rd_bin;
    assign burst_avail = (rd_fill >= burst_beats);   // pessimistic, fill only grows late

    // producer and consumer must honour the flags of the other domain
    no_write_full: assert property (@(posedge wr_clk) disable iff (!wr_rstn)
        wr_en |-> !full)
        else $error("FIFO written while full");

    no_read_empty: assert property (@(posedge rd_clk) disable iff (!rd_rstn)
        rd_en |-> !empty)
        else $error("FIFO read while empty");

endmodule
